// File: rtl/icache_geom_pkg.sv
`default_nettype none

package icache_geom_pkg;

    // address split: tag | index | offset
    localparam int offset_bits = 3;     // 8 byte line
    localparam int index_bits = 6;
    localparam int num_sets = 1 << index_bits;
    localparam int num_ways = 2;

    localparam int line_bits = 64;

    // one line is exactly one fetch word
    typedef logic [line_bits-1:0] line_t;

    // result of a tag lookup, valid one cycle after the index
    typedef struct packed {
        logic hit;
        logic hit_way;
        logic victim;   // lru way of the set
    } lookup_t;

endpackage

`default_nettype wire

// File: rtl/icache_ctrl_pkg.sv
`default_nettype none

package icache_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill_wait,
        st_uncached_wait,
        st_flush
    } ctrl_state_e;

    typedef enum logic [1:0] {
        reg_ctrl       = 2'd0,
        reg_hit_count  = 2'd1,
        reg_miss_count = 2'd2
    } cfg_reg_e;

    typedef struct packed {
        logic enable;
        logic flush;    // one cycle
    } cfg_t;

endpackage

`default_nettype wire

// File: rtl/icache_data.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [icache_geom_pkg::index_bits-1:0] index,
    input  logic                                  rd_way,
    input  logic                                  fill_en,
    input  logic                                  fill_way,
    input  icache_geom_pkg::line_t                fill_line,
    output icache_geom_pkg::line_t                rd_line
);

    icache_geom_pkg::line_t mem [icache_geom_pkg::num_ways][icache_geom_pkg::num_sets];
    icache_geom_pkg::line_t rd_q [icache_geom_pkg::num_ways];

    // refill writes only the victim way
    always_ff @(posedge clk) begin
        if (fill_en) begin
            mem[fill_way][index] <= fill_line;
        end
    end

    // both ways read every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
                rd_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
                rd_q[w] <= mem[w][index];
            end
        end
    end

    // way select after the register, hit way arrives with the lookup
    assign rd_line = rd_q[rd_way];

endmodule

`default_nettype wire

// File: rtl/icache_tag.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag #(
    parameter int addr_width = 32,
    localparam int tag_bits = addr_width - icache_geom_pkg::index_bits
                              - icache_geom_pkg::offset_bits
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [icache_geom_pkg::index_bits-1:0] index,
    input  logic [tag_bits-1:0]                   tag,
    input  logic                                  fill_en,
    input  logic                                  fill_way,
    input  logic                                  clear_en,
    input  logic                                  touch_en,
    output icache_geom_pkg::lookup_t              lookup
);

    logic [tag_bits-1:0] tag_mem [icache_geom_pkg::num_ways][icache_geom_pkg::num_sets];
    logic [icache_geom_pkg::num_ways-1:0][icache_geom_pkg::num_sets-1:0] valid;
    logic [icache_geom_pkg::num_sets-1:0] lru;    // points at the victim way

    logic [tag_bits-1:0] tag_q [icache_geom_pkg::num_ways];
    logic [tag_bits-1:0] tag_r;                   // requested tag, registered
    logic [icache_geom_pkg::num_ways-1:0] valid_q;
    logic [icache_geom_pkg::num_ways-1:0] way_hit;
    logic lru_q;

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            lru <= '0;
        end else begin
            if (clear_en) begin
                valid[0][index] <= 1'b0;
                valid[1][index] <= 1'b0;
            end else if (fill_en) begin
                valid[fill_way][index] <= 1'b1;
            end
            if (fill_en) begin
                lru[index] <= ~fill_way;
            end else if (touch_en) begin
                lru[index] <= ~lookup.hit_way;  // registered index equals index here
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            lru_q <= 1'b0;
        end else begin
            valid_q <= {valid[1][index], valid[0][index]};
            lru_q <= lru[index];
        end
    end

    always_ff @(posedge clk) begin
        tag_r <= tag;
        for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
            tag_q[w] <= tag_mem[w][index];
        end
    end

    always_comb begin
        for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
            way_hit[w] = valid_q[w] && (tag_q[w] == tag_r);
        end
    end

    assign lookup.hit = |way_hit;
    assign lookup.hit_way = way_hit[1];
    assign lookup.victim = lru_q;

endmodule

`default_nettype wire

// File: rtl/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int addr_width = 32,
    localparam int tag_lo = icache_geom_pkg::offset_bits + icache_geom_pkg::index_bits,
    localparam int tag_bits = addr_width - tag_lo
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  fetch_req,
    input  logic [addr_width-1:0]                 fetch_addr,
    output logic                                  fetch_ready,
    output logic                                  fetch_valid,
    output icache_geom_pkg::line_t                fetch_data,
    output logic                                  mem_req,
    output logic [addr_width-1:0]                 mem_addr,
    input  logic                                  mem_valid,
    input  icache_geom_pkg::line_t                mem_data,
    input  icache_ctrl_pkg::cfg_t                 cfg,
    input  icache_geom_pkg::lookup_t              lookup,
    input  icache_geom_pkg::line_t                rd_line,
    output logic [icache_geom_pkg::index_bits-1:0] index,
    output logic [tag_bits-1:0]                   tag,
    output logic                                  fill_en,
    output logic                                  fill_way,
    output icache_geom_pkg::line_t                fill_line,
    output logic                                  clear_en,
    output logic                                  touch_en,
    output logic                                  hit_pulse,
    output logic                                  miss_pulse
);

    localparam int idx_lo = icache_geom_pkg::offset_bits;

    icache_ctrl_pkg::ctrl_state_e state, state_nxt;

    logic [addr_width-1:0] req_addr;
    logic cached_q;     // enable sampled with the request
    logic victim_q;
    logic flush_pend;
    logic [icache_geom_pkg::index_bits-1:0] flush_idx;
    logic mem_valid_q;
    icache_geom_pkg::line_t mem_data_q;
    logic in_lookup, hit_now, wait_done;

    assign in_lookup = (state == icache_ctrl_pkg::st_lookup);
    assign hit_now = in_lookup && cached_q && lookup.hit;
    assign wait_done = mem_valid_q && (state == icache_ctrl_pkg::st_refill_wait ||
                                       state == icache_ctrl_pkg::st_uncached_wait);

    always_comb begin
        state_nxt = state;
        case (state)
            icache_ctrl_pkg::st_idle: begin
                if (fetch_req)
                    state_nxt = icache_ctrl_pkg::st_lookup;
                else if (cfg.flush || flush_pend)
                    state_nxt = icache_ctrl_pkg::st_flush;
            end
            icache_ctrl_pkg::st_lookup: begin
                if (hit_now)
                    state_nxt = icache_ctrl_pkg::st_idle;
                else if (cached_q)
                    state_nxt = icache_ctrl_pkg::st_refill_wait;
                else
                    state_nxt = icache_ctrl_pkg::st_uncached_wait;
            end
            icache_ctrl_pkg::st_refill_wait,
            icache_ctrl_pkg::st_uncached_wait: begin
                if (mem_valid_q) state_nxt = icache_ctrl_pkg::st_idle;
            end
            icache_ctrl_pkg::st_flush: begin
                if (flush_idx == '1) state_nxt = icache_ctrl_pkg::st_idle;
            end
            default: state_nxt = icache_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_ctrl_pkg::st_idle;
            cached_q <= 1'b0;
            flush_pend <= 1'b0;
            flush_idx <= '0;
            mem_valid_q <= 1'b0;
        end else begin
            state <= state_nxt;
            mem_valid_q <= mem_valid;
            if (state == icache_ctrl_pkg::st_idle && fetch_req) cached_q <= cfg.enable;
            if (cfg.flush) flush_pend <= 1'b1;
            else if (state == icache_ctrl_pkg::st_flush) flush_pend <= 1'b0;
            if (state == icache_ctrl_pkg::st_flush) flush_idx <= flush_idx + 1'b1;
        end
    end

    // request and refill payload
    always_ff @(posedge clk) begin
        if (state == icache_ctrl_pkg::st_idle && fetch_req) req_addr <= fetch_addr;
        if (in_lookup) victim_q <= lookup.victim;
        if (mem_valid) mem_data_q <= mem_data;
    end

    always_comb begin
        case (state)
            icache_ctrl_pkg::st_idle: index = fetch_addr[tag_lo-1:idx_lo];
            icache_ctrl_pkg::st_flush: index = flush_idx;
            default: index = req_addr[tag_lo-1:idx_lo];
        endcase
    end

    assign tag = (state == icache_ctrl_pkg::st_idle) ? fetch_addr[addr_width-1:tag_lo]
                                                      : req_addr[addr_width-1:tag_lo];

    assign fetch_ready = (state == icache_ctrl_pkg::st_idle);
    assign fetch_valid = hit_now || wait_done;
    assign fetch_data = in_lookup ? rd_line : mem_data_q;  // refill data forwarded

    assign mem_req = in_lookup && !hit_now;
    assign mem_addr = {req_addr[addr_width-1:idx_lo], {idx_lo{1'b0}}};

    assign fill_en = mem_valid_q && (state == icache_ctrl_pkg::st_refill_wait);
    assign fill_way = victim_q;
    assign fill_line = mem_data_q;
    assign clear_en = (state == icache_ctrl_pkg::st_flush);
    assign touch_en = hit_now;

    assign hit_pulse = hit_now;
    assign miss_pulse = in_lookup && cached_q && !lookup.hit;  // uncached not counted

endmodule

`default_nettype wire

// File: rtl/icache_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module icache_cfg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cfg_we,
    input  logic [1:0]            cfg_addr,
    input  logic [31:0]           cfg_wdata,
    output logic [31:0]           cfg_rdata,
    input  logic                  hit_pulse,
    input  logic                  miss_pulse,
    output icache_ctrl_pkg::cfg_t cfg
);

    icache_ctrl_pkg::cfg_reg_e reg_sel;

    logic ctrl_wr;
    logic enable;
    logic flush_q;
    logic [1:0] pulse;
    logic [1:0][31:0] count;    // 0 hit, 1 miss

    assign reg_sel = icache_ctrl_pkg::cfg_reg_e'(cfg_addr);
    assign ctrl_wr = cfg_we && (reg_sel == icache_ctrl_pkg::reg_ctrl);
    assign pulse = {miss_pulse, hit_pulse};

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b1;
            flush_q <= 1'b0;
        end else begin
            flush_q <= ctrl_wr && cfg_wdata[1];
            if (ctrl_wr) enable <= cfg_wdata[0];
        end
    end

    // saturating, cleared by any ctrl write
    always_ff @(posedge clk) begin
        if (rst || ctrl_wr) begin
            count <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (pulse[i] && count[i] != '1) count[i] <= count[i] + 32'd1;
            end
        end
    end

    always_comb begin
        case (reg_sel)
            icache_ctrl_pkg::reg_ctrl:       cfg_rdata = {31'b0, enable};
            icache_ctrl_pkg::reg_hit_count:  cfg_rdata = count[0];
            icache_ctrl_pkg::reg_miss_count: cfg_rdata = count[1];
            default:                         cfg_rdata = '0;
        endcase
    end

    assign cfg.enable = enable;
    assign cfg.flush = flush_q;

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int addr_width = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  logic [addr_width-1:0]  fetch_addr,
    output logic                   fetch_ready,
    output logic                   fetch_valid,
    output icache_geom_pkg::line_t fetch_data,
    output logic                   mem_req,
    output logic [addr_width-1:0]  mem_addr,
    input  logic                   mem_valid,
    input  icache_geom_pkg::line_t mem_data,
    input  logic                   cfg_we,
    input  logic [1:0]             cfg_addr,
    input  logic [31:0]            cfg_wdata,
    output logic [31:0]            cfg_rdata
);

    localparam int tag_bits = addr_width - icache_geom_pkg::index_bits
                              - icache_geom_pkg::offset_bits;

    icache_ctrl_pkg::cfg_t cfg;
    icache_geom_pkg::lookup_t lookup;
    icache_geom_pkg::line_t rd_line;
    icache_geom_pkg::line_t fill_line;
    logic [icache_geom_pkg::index_bits-1:0] index;
    logic [tag_bits-1:0] tag;
    logic fill_en, fill_way, clear_en, touch_en;
    logic hit_pulse, miss_pulse;

    icache_cfg icache_cfg_i (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse),
        .cfg        (cfg)
    );

    icache_ctrl #(.addr_width(addr_width)) icache_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .cfg         (cfg),
        .lookup      (lookup),
        .rd_line     (rd_line),
        .index       (index),
        .tag         (tag),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_line   (fill_line),
        .clear_en    (clear_en),
        .touch_en    (touch_en),
        .hit_pulse   (hit_pulse),
        .miss_pulse  (miss_pulse)
    );

    icache_tag #(.addr_width(addr_width)) icache_tag_i (
        .clk      (clk),
        .rst      (rst),
        .index    (index),
        .tag      (tag),
        .fill_en  (fill_en),
        .fill_way (fill_way),
        .clear_en (clear_en),
        .touch_en (touch_en),
        .lookup   (lookup)
    );

    // hit way picks the registered line
    icache_data icache_data_i (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .rd_way    (lookup.hit_way),
        .fill_en   (fill_en),
        .fill_way  (fill_way),
        .fill_line (fill_line),
        .rd_line   (rd_line)
    );

endmodule

`default_nettype wire

// File: dv/icache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module icache_checker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_req,
    input  logic [31:0]            fetch_addr,
    input  logic                   fetch_ready,
    input  logic                   fetch_valid,
    input  icache_geom_pkg::line_t fetch_data,
    input  logic                   mem_req,
    input  logic [31:0]            cfg_rdata,
    input  logic                   exp_miss,
    input  logic                   rd_chk,
    input  logic [31:0]            exp_rdata,
    output int                     errors,
    output int                     checks
);

    logic pend;         // fetch outstanding
    logic saw_mem;
    logic was_rst;
    logic [31:0] req_addr;
    int cycles;         // edges since the request

    // memory contents: line address in both halves, scrambled
    function automatic logic [63:0] expected_line(input logic [31:0] addr);
        logic [31:0] line_addr;
        line_addr = {addr[31:3], 3'b000};
        return {line_addr, line_addr} ^ 64'h5a5a_0000_a5a5_0000;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        pend = 1'b0;
        saw_mem = 1'b0;
        was_rst = 1'b0;
        req_addr = '0;
        cycles = 0;
    end

    // sampled on the DUT's own edge, inputs are driven on the falling edge
    always @(posedge clk) begin
        if (rst) begin
            was_rst = 1'b1;
            pend = 1'b0;
        end else begin
            if (was_rst) begin
                compare_value("fetch_valid after reset", 64'd0, fetch_valid);
                compare_value("mem_req after reset", 64'd0, mem_req);
                compare_value("fetch_ready after reset", 64'd1, fetch_ready);
                was_rst = 1'b0;
            end
            if (rd_chk) compare_value("cfg_rdata", exp_rdata, cfg_rdata);
            if (fetch_req) begin
                pend = 1'b1;
                req_addr = fetch_addr;
                cycles = 0;
                saw_mem = 1'b0;
            end else if (pend) begin
                cycles++;
                compare_value("fetch_ready while busy", 64'd0, fetch_ready);
                if (mem_req) begin
                    saw_mem = 1'b1;
                    compare_value("mem_req delay", 64'd1, cycles);
                end
                if (fetch_valid) begin
                    compare_value("fetch_data", expected_line(req_addr), fetch_data);
                    compare_value("mem_req per fetch", exp_miss, saw_mem);
                    if (!exp_miss) compare_value("hit latency", 64'd1, cycles);
                    pend = 1'b0;
                end
            end else if (fetch_valid || mem_req) begin
                errors++;
                $display("fetch_valid or mem_req pulsed at %0t with no fetch outstanding",
                         $time);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    typedef enum logic [1:0] {
        op_fetch,
        op_write,
        op_read
    } op_e;

    typedef struct packed {
        op_e         op;
        logic [31:0] addr;      // fetch address or config register
        logic [31:0] wdata;
        logic        miss;
        logic [31:0] rdata;
    } row_t;

    logic clk;
    logic rst;
    logic fetch_req;
    logic [31:0] fetch_addr;
    logic fetch_ready;
    logic fetch_valid;
    icache_geom_pkg::line_t fetch_data;
    logic mem_req;
    logic [31:0] mem_addr;
    logic mem_valid;
    icache_geom_pkg::line_t mem_data;
    logic cfg_we;
    logic [1:0] cfg_addr;
    logic [31:0] cfg_wdata;
    logic [31:0] cfg_rdata;

    logic exp_miss;
    logic rd_chk;
    logic [31:0] exp_rdata;
    int errors;
    int checks;
    int timeouts;
    integer seed = 32'hed16_3e04;
    row_t rows[$];

    icache_top #(.addr_width(32)) icache_top_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata)
    );

    icache_checker icache_checker (
        .clk         (clk),
        .rst         (rst),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .mem_req     (mem_req),
        .cfg_rdata   (cfg_rdata),
        .exp_miss    (exp_miss),
        .rd_chk      (rd_chk),
        .exp_rdata   (exp_rdata),
        .errors      (errors),
        .checks      (checks)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic icache_geom_pkg::line_t line_pattern(input logic [31:0] addr);
        return {addr, addr} ^ 64'h5a5a_0000_a5a5_0000;
    endfunction

    // memory model, one request at a time
    initial begin
        logic [31:0] line_addr;
        int delay;
        mem_valid = 1'b0;
        mem_data = '0;
        forever begin
            @(posedge clk);
            if (!rst && mem_req) begin
                line_addr = mem_addr;
                delay = 1 + ($unsigned($random(seed)) % 5);
                repeat (delay) @(negedge clk);
                mem_valid = 1'b1;
                mem_data = line_pattern(line_addr);
                @(negedge clk);
                mem_valid = 1'b0;
            end
        end
    end

    task automatic add_fetch(input logic [31:0] addr, input logic miss);
        rows.push_back('{op_fetch, addr, 32'd0, miss, 32'd0});
    endtask

    task automatic add_write(input icache_ctrl_pkg::cfg_reg_e reg_sel, input logic [31:0] data);
        rows.push_back('{op_write, 32'(reg_sel), data, 1'b0, 32'd0});
    endtask

    task automatic add_read(input icache_ctrl_pkg::cfg_reg_e reg_sel, input logic [31:0] value);
        rows.push_back('{op_read, 32'(reg_sel), 32'd0, 1'b0, value});
    endtask

    task automatic wait_ready_level(input logic level, input string what);
        int n;
        n = 0;
        while (fetch_ready !== level && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (fetch_ready !== level) begin
            timeouts++;
            $display("timeout at %0t: fetch_ready never went %0b while %s", $time, level, what);
        end
    endtask

    task automatic wait_valid(input logic [31:0] addr);
        int n;
        n = 0;
        while (fetch_valid !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (fetch_valid !== 1'b1) begin
            timeouts++;
            $display("timeout at %0t: no fetch_valid for address %h", $time, addr);
        end
    endtask

    task automatic do_fetch(input row_t r);
        wait_ready_level(1'b1, "waiting to fetch");
        fetch_req = 1'b1;
        fetch_addr = r.addr;
        exp_miss = r.miss;
        @(negedge clk);
        fetch_req = 1'b0;
        wait_valid(r.addr);
        @(negedge clk);
    endtask

    task automatic do_write(input row_t r);
        cfg_we = 1'b1;
        cfg_addr = r.addr[1:0];
        cfg_wdata = r.wdata;
        @(negedge clk);
        cfg_we = 1'b0;
        if (r.wdata[1]) begin   // flush starts two cycles later
            wait_ready_level(1'b0, "starting a flush");
            wait_ready_level(1'b1, "flushing");
        end
    endtask

    task automatic do_read(input row_t r);
        cfg_addr = r.addr[1:0];
        exp_rdata = r.rdata;
        rd_chk = 1'b1;
        @(negedge clk);
        rd_chk = 1'b0;
    endtask

    task automatic build_table();
        add_fetch(32'h0000_1000, 1'b1);
        add_fetch(32'h0000_1000, 1'b0);
        add_fetch(32'h0000_01f8, 1'b1);     // last set
        add_fetch(32'h0000_0040, 1'b1);     // a, b and c share set 8
        add_fetch(32'h0000_0240, 1'b1);
        add_fetch(32'h0000_0040, 1'b0);
        add_fetch(32'h0000_0440, 1'b1);     // evicts b
        add_fetch(32'h0000_0040, 1'b0);
        add_fetch(32'h0000_0240, 1'b1);
        add_read(icache_ctrl_pkg::reg_hit_count, 32'd3);
        add_read(icache_ctrl_pkg::reg_miss_count, 32'd6);
        add_write(icache_ctrl_pkg::reg_ctrl, 32'd0);
        add_read(icache_ctrl_pkg::reg_ctrl, 32'd0);
        add_fetch(32'h0000_2000, 1'b1);
        add_fetch(32'h0000_2000, 1'b1);
        add_fetch(32'h0000_1000, 1'b1);     // resident but bypassed
        add_fetch(32'h0000_2000, 1'b1);
        add_read(icache_ctrl_pkg::reg_hit_count, 32'd0);
        add_read(icache_ctrl_pkg::reg_miss_count, 32'd0);
        add_write(icache_ctrl_pkg::reg_ctrl, 32'd1);
        add_read(icache_ctrl_pkg::reg_ctrl, 32'd1);
        add_fetch(32'h0000_2000, 1'b1);
        add_fetch(32'h0000_2000, 1'b0);
        add_fetch(32'h0000_1000, 1'b0);
        add_read(icache_ctrl_pkg::reg_hit_count, 32'd2);
        add_read(icache_ctrl_pkg::reg_miss_count, 32'd1);
        add_write(icache_ctrl_pkg::reg_ctrl, 32'd3);   // enable and flush
        add_read(icache_ctrl_pkg::reg_ctrl, 32'd1);
        add_fetch(32'h0000_1000, 1'b1);
        add_fetch(32'h0000_01f8, 1'b1);
        add_fetch(32'h0000_0040, 1'b1);
        add_fetch(32'h0000_2000, 1'b1);
        add_fetch(32'h0000_1000, 1'b0);
        add_fetch(32'h0000_0040, 1'b0);
        add_read(icache_ctrl_pkg::reg_hit_count, 32'd2);
        add_read(icache_ctrl_pkg::reg_miss_count, 32'd4);
    endtask

    initial begin
        int i;
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        exp_miss = 1'b0;
        rd_chk = 1'b0;
        exp_rdata = '0;
        timeouts = 0;
        build_table();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (i = 0; i < rows.size(); i++) begin
            case (rows[i].op)
                op_fetch: do_fetch(rows[i]);
                op_write: do_write(rows[i]);
                default:  do_read(rows[i]);
            endcase
        end
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_top.f
rtl/icache_geom_pkg.sv
rtl/icache_ctrl_pkg.sv
rtl/icache_data.sv
rtl/icache_tag.sv
rtl/icache_ctrl.sv
rtl/icache_cfg.sv
rtl/icache_top.sv
dv/icache_checker.sv
dv/icache_tb.sv
